//--- compile.f
verilog/dmac_dest_pkg.sv
verilog/dmac_req_splitter.sv
verilog/dmac_address_generator.sv
verilog/dmac_data_mover.sv
verilog/dmac_response_handler.sv
verilog/dmac_dest_mm_axi.sv
dv/dmac_dest_assertions.sv
dv/dmac_dest_tb.sv

//--- dv/dmac_dest_assertions.sv
// Protocol checks for the DMA destination write master
// AW and W handshake stability and the burst ID window, bound into
// the top level where every channel and ID is visible

`default_nettype none

module dmac_dest_assertions #(
  parameter int ID_WIDTH = 3,
  parameter int ADDR_WIDTH = 32
) (
  input logic                  m_axi_aclk,
  input logic                  rst_n,
  input logic                  m_axi_awvalid,
  input logic                  m_axi_awready,
  input logic [ADDR_WIDTH-1:0] m_axi_awaddr,
  input logic [7:0]            m_axi_awlen,
  input logic                  m_axi_wvalid,
  input logic                  m_axi_wready,
  input logic                  m_axi_bvalid,
  input logic                  m_axi_bready,
  input logic [ID_WIDTH-1:0]   address_id,
  input logic [ID_WIDTH-1:0]   response_id
);

  logic [ID_WIDTH-1:0] id_distance;
  logic [ID_WIDTH:0]   in_flight;

  assign id_distance = address_id - response_id;

  // AW bursts still waiting for their B response
  always_ff @(posedge m_axi_aclk) begin
    if (!rst_n) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight + (m_axi_awvalid && m_axi_awready)
                             - (m_axi_bvalid && m_axi_bready);
    end
  end

  aw_stable: assert property (@(posedge m_axi_aclk) disable iff (!rst_n)
    m_axi_awvalid && !m_axi_awready |=>
      m_axi_awvalid && $stable(m_axi_awaddr) && $stable(m_axi_awlen))
    else $error("AW valid or payload changed before awready");

  w_stable: assert property (@(posedge m_axi_aclk) disable iff (!rst_n)
    m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid)
    else $error("W valid dropped before wready");

  // The ID distance follows the handshakes and stays below 2^ID_WIDTH
  id_window: assert property (@(posedge m_axi_aclk) disable iff (!rst_n)
    !in_flight[ID_WIDTH] && id_distance == in_flight[ID_WIDTH-1:0])
    else $error("Burst ID window overflow or burst IDs out of step");

endmodule

bind dmac_dest_mm_axi dmac_dest_assertions #(
  .ID_WIDTH   (ID_WIDTH),
  .ADDR_WIDTH (ADDR_WIDTH)
) u_assertions (
  .m_axi_aclk    (m_axi_aclk),
  .rst_n         (rst_n),
  .m_axi_awvalid (m_axi_awvalid),
  .m_axi_awready (m_axi_awready),
  .m_axi_awaddr  (m_axi_awaddr),
  .m_axi_awlen   (m_axi_awlen),
  .m_axi_wvalid  (m_axi_wvalid),
  .m_axi_wready  (m_axi_wready),
  .m_axi_bvalid  (m_axi_bvalid),
  .m_axi_bready  (m_axi_bready),
  .address_id    (address_id),
  .response_id   (response_id)
);

`default_nettype wire

//--- dv/dmac_dest_tb.sv
// Testbench for the DMA destination AXI4 write master
// Random bursts, FIFO data and AXI slave timing, checked against a
// reference model of the AW, W and response streams

`default_nettype none

module dmac_dest_tb;

  localparam int ID_WIDTH = 3;
  localparam int DATA_WIDTH = 64;
  localparam int ADDR_WIDTH = 32;
  localparam int BPB_WIDTH = 4;
  localparam int BYTES_WIDTH = 3;
  localparam int NUM_BURSTS = 60;
  localparam int TIMEOUT = 20000;
  localparam int NUM_TESTS = 6;

  // Test indices
  localparam int T_RESET = 0;
  localparam int T_AW = 1;
  localparam int T_W = 2;
  localparam int T_RESP = 3;
  localparam int T_BP = 4;
  localparam int T_DIS = 5;

  logic m_axi_aclk = 1'b0;
  logic rst_n, enable, enabled;
  logic req_valid, req_ready, req_eot;
  logic [ADDR_WIDTH-1:BYTES_WIDTH] req_address;
  logic [BPB_WIDTH-1:0] req_last_burst_length;
  logic [BYTES_WIDTH-1:0] req_last_beat_bytes;
  logic fifo_valid, fifo_ready;
  logic [DATA_WIDTH-1:0] fifo_data;
  logic m_axi_awvalid, m_axi_awready;
  logic [ADDR_WIDTH-1:0] m_axi_awaddr;
  logic [7:0] m_axi_awlen;
  logic [2:0] m_axi_awsize, m_axi_awprot;
  logic [3:0] m_axi_awcache;
  dmac_dest_pkg::axi_burst_e m_axi_awburst;
  logic m_axi_wvalid, m_axi_wready, m_axi_wlast;
  logic [DATA_WIDTH-1:0] m_axi_wdata;
  logic [DATA_WIDTH/8-1:0] m_axi_wstrb;
  logic m_axi_bvalid, m_axi_bready;
  dmac_dest_pkg::axi_resp_e m_axi_bresp;
  logic response_valid, response_ready;
  dmac_dest_pkg::dest_resp_t response;

  // Reference model
  logic [ADDR_WIDTH-1:BYTES_WIDTH] burst_addr [NUM_BURSTS];
  logic [BPB_WIDTH-1:0] burst_len [NUM_BURSTS];
  logic [BYTES_WIDTH-1:0] burst_bytes [NUM_BURSTS];
  logic burst_eot [NUM_BURSTS];
  logic [DATA_WIDTH-1:0] beat_data [$];
  dmac_dest_pkg::axi_resp_e bresp_q [$];

  int err_cnt [NUM_TESTS];
  string test_name [NUM_TESTS] = '{"reset", "aw_stream", "w_stream", "responses",
                                   "back_pressure", "disable"};
  int req_sent, fifo_sent, aw_count, w_beat, w_burst, burst_beat, wlast_count;
  int b_done, resp_count;
  logic req_fire, fifo_fire, b_fire;
  logic traffic_on, fifo_on, flush_on, stray_on;

  always #20 m_axi_aclk = ~m_axi_aclk;

  dmac_dest_mm_axi #(
    .ID_WIDTH              (ID_WIDTH),
    .DATA_WIDTH            (DATA_WIDTH),
    .ADDR_WIDTH            (ADDR_WIDTH),
    .BEATS_PER_BURST_WIDTH (BPB_WIDTH)
  ) UUT (.*);

  task automatic report_value(input int test, input string what,
                              input logic [63:0] exp, input logic [63:0] act);
    err_cnt[test]++;
    $display("FAIL %s %s: expected %0h, actual %0h", test_name[test], what, exp, act);
  endtask

  task automatic report_text(input int test, input string what);
    err_cnt[test]++;
    $display("ERROR %s: %s", test_name[test], what);
  endtask

  task automatic close_test(input int test);
    if (err_cnt[test] == 0) begin
      $display("test %s: passed", test_name[test]);
    end else begin
      $display("test %s: %0d errors", test_name[test], err_cnt[test]);
    end
  endtask

  task automatic finish_run(input logic timed_out);
    int bad;
    bad = 0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      if (err_cnt[i] != 0) begin
        bad++;
      end
    end
    $display("summary: %0d tests, %0d with errors", NUM_TESTS, bad);
    if (bad == 0 && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  task automatic wait_enabled(input logic level);
    int n;
    n = 0;
    while (enabled !== level && n < TIMEOUT) begin
      @(negedge m_axi_aclk);
      n++;
    end
    if (enabled !== level) begin
      $display("ERROR: enabled did not reach %0b in time", level);
      finish_run(1'b1);
    end
  endtask

  task automatic wait_responses(input int count);
    int n;
    n = 0;
    while (resp_count < count && n < TIMEOUT) begin
      @(negedge m_axi_aclk);
      n++;
    end
    if (resp_count < count) begin
      $display("ERROR: only %0d of %0d responses arrived in time", resp_count, count);
      finish_run(1'b1);
    end
  endtask

  // **************************************************
  // Monitor sampling mid-cycle where everything has settled
  // **************************************************

  always @(negedge m_axi_aclk) begin
    logic [7:0] exp_strb;
    logic exp_last;
    req_fire = req_valid && req_ready;
    fifo_fire = fifo_valid && fifo_ready;
    b_fire = m_axi_bvalid && m_axi_bready;
    if (rst_n) begin
      if (req_fire) req_sent++;
      if (fifo_fire && fifo_on) fifo_sent++;
      if (b_fire) b_done++;
      if (m_axi_awvalid && m_axi_awready) begin
        if (aw_count < NUM_BURSTS) begin
          assert (m_axi_awaddr == {burst_addr[aw_count], 3'b000})
            else report_value(T_AW, "awaddr", {burst_addr[aw_count], 3'b000}, m_axi_awaddr);
          assert (m_axi_awlen == 8'(burst_len[aw_count]))
            else report_value(T_AW, "awlen", burst_len[aw_count], m_axi_awlen);
          assert (m_axi_awburst == dmac_dest_pkg::INCR && m_axi_awsize == 3'd3)
            else report_value(T_AW, "awburst/awsize", 5'h0b, {m_axi_awburst, m_axi_awsize});
          assert (m_axi_awprot == 3'b000 && m_axi_awcache == 4'b0011)
            else report_value(T_AW, "awprot/awcache", 7'h03, {m_axi_awprot, m_axi_awcache});
        end else begin
          report_text(T_AW, "AW burst issued beyond the requested bursts");
        end
        aw_count++;
      end
      if (m_axi_wvalid && m_axi_wready) begin
        if (w_burst < NUM_BURSTS) begin
          exp_last = burst_beat == int'(burst_len[w_burst]);
          exp_strb = 8'hff;
          if (exp_last && burst_eot[w_burst]) begin
            exp_strb = 8'((1 << (int'(burst_bytes[w_burst]) + 1)) - 1);
          end
          assert (m_axi_wdata == beat_data[w_beat])
            else report_value(T_W, "wdata", beat_data[w_beat], m_axi_wdata);
          assert (m_axi_wlast == exp_last)
            else report_value(T_W, "wlast", exp_last, m_axi_wlast);
          assert (m_axi_wstrb == exp_strb)
            else report_value(T_W, "wstrb", exp_strb, m_axi_wstrb);
          w_beat++;
          burst_beat = exp_last ? 0 : burst_beat + 1;
          if (exp_last) w_burst++;
        end else begin
          report_text(T_W, "W beat issued beyond the requested bursts");
        end
        if (m_axi_wlast) wlast_count++;
      end
      if (response_valid && response_ready) begin
        if (resp_count < bresp_q.size()) begin
          assert (response.resp == bresp_q[resp_count])
            else report_value(T_RESP, "resp", bresp_q[resp_count], response.resp);
          assert (response.eot == burst_eot[resp_count])
            else report_value(T_RESP, "eot", burst_eot[resp_count], response.eot);
        end else begin
          report_text(T_BP, "response without a matching B response");
        end
        resp_count++;
      end
      assert (aw_count - b_done <= 7)
        else report_value(T_BP, "outstanding AW bursts", 7, aw_count - b_done);
    end
  end

  // **************************************************
  // Drivers acting a short delay after the rising edge
  // **************************************************

  always @(posedge m_axi_aclk) begin
    #2;
    if (req_fire || !req_valid) begin
      req_valid = 1'b0;
      if (traffic_on && req_sent < NUM_BURSTS && $urandom_range(3) != 0) begin
        req_valid = 1'b1;
        req_address = burst_addr[req_sent];
        req_last_burst_length = burst_len[req_sent];
        req_last_beat_bytes = burst_bytes[req_sent];
        req_eot = burst_eot[req_sent];
      end else if (stray_on) begin
        // Offered while disabled and never to be taken
        req_valid = 1'b1;
        req_address = {$urandom, $urandom};
      end
    end
    if (fifo_fire || !fifo_valid) begin
      fifo_valid = 1'b0;
      if (fifo_on && fifo_sent < beat_data.size() && $urandom_range(3) != 0) begin
        fifo_valid = 1'b1;
        fifo_data = beat_data[fifo_sent];
      end else if (flush_on && $urandom_range(1) != 0) begin
        fifo_valid = 1'b1;
        fifo_data = {$urandom, $urandom};
      end
    end
    m_axi_awready = $urandom_range(2) != 0;
    m_axi_wready = $urandom_range(3) != 0;
    response_ready = $urandom_range(2) == 0;
    // B follows completed W bursts only
    if (b_fire || !m_axi_bvalid) begin
      m_axi_bvalid = 1'b0;
      if (wlast_count > b_done && $urandom_range(2) != 0) begin
        m_axi_bvalid = 1'b1;
        m_axi_bresp = ($urandom_range(1) != 0) ? dmac_dest_pkg::SLVERR : dmac_dest_pkg::OKAY;
        bresp_q.push_back(m_axi_bresp);
      end
    end
  end

  // **************************************************
  // Test sequence
  // **************************************************

  initial begin
    int beats;
    int extra;
    void'($urandom(32'h9dda));
    rst_n = 1'b0;
    enable = 1'b0;
    req_valid = 1'b0;
    req_address = '0;
    req_last_burst_length = '0;
    req_last_beat_bytes = '0;
    req_eot = 1'b0;
    fifo_valid = 1'b0;
    fifo_data = '0;
    m_axi_awready = 1'b0;
    m_axi_wready = 1'b0;
    m_axi_bvalid = 1'b0;
    m_axi_bresp = dmac_dest_pkg::OKAY;
    response_ready = 1'b0;
    traffic_on = 1'b0;
    fifo_on = 1'b0;
    flush_on = 1'b0;
    stray_on = 1'b0;
    req_fire = 1'b0;
    fifo_fire = 1'b0;
    b_fire = 1'b0;
    beats = 0;
    for (int i = 0; i < NUM_BURSTS; i++) begin
      burst_addr[i] = {$urandom, $urandom};
      burst_len[i] = BPB_WIDTH'($urandom);
      burst_bytes[i] = BYTES_WIDTH'($urandom);
      burst_eot[i] = $urandom_range(1) != 0;
      beats += int'(burst_len[i]) + 1;
    end
    for (int i = 0; i < beats; i++) begin
      beat_data.push_back({$urandom, $urandom});
    end

    repeat (16) @(posedge m_axi_aclk);
    #2 rst_n = 1'b1;
    @(negedge m_axi_aclk);
    assert ({m_axi_awvalid, m_axi_wvalid, m_axi_bready, response_valid,
             req_ready, enabled} == 6'b0)
      else report_value(T_RESET, "control outputs", 0,
                        {m_axi_awvalid, m_axi_wvalid, m_axi_bready, response_valid,
                         req_ready, enabled});
    close_test(T_RESET);

    @(posedge m_axi_aclk);
    #2 enable = 1'b1;
    traffic_on = 1'b1;
    // The data mover sinks FIFO beats until it is enabled
    wait_enabled(1'b1);
    fifo_on = 1'b1;
    wait_responses(NUM_BURSTS);
    extra = resp_count;
    repeat (20) @(negedge m_axi_aclk);

    assert (aw_count == NUM_BURSTS)
      else report_value(T_AW, "AW burst count", NUM_BURSTS, aw_count);
    close_test(T_AW);
    assert (w_beat == beats && fifo_sent == beats)
      else report_value(T_W, "W beat count", beats, w_beat);
    close_test(T_W);
    assert (bresp_q.size() == NUM_BURSTS)
      else report_value(T_RESP, "B response count", NUM_BURSTS, bresp_q.size());
    close_test(T_RESP);
    assert (resp_count == extra && resp_count == NUM_BURSTS)
      else report_value(T_BP, "response count", NUM_BURSTS, resp_count);
    close_test(T_BP);

    @(posedge m_axi_aclk);
    #2 enable = 1'b0;
    fifo_on = 1'b0;
    wait_enabled(1'b0);
    flush_on = 1'b1;
    stray_on = 1'b1;
    repeat (40) begin
      @(negedge m_axi_aclk);
      assert (fifo_ready && !req_ready && !m_axi_awvalid && !m_axi_wvalid)
        else report_text(T_DIS, "FIFO not flushed, request taken or AXI traffic while disabled");
    end
    close_test(T_DIS);
    finish_run(1'b0);
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds the DMA destination testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dmac_dest_tb \
  -f compile.f -o sim_dmac_dest > build.log 2>&1 \
  && ./obj_dir/sim_dmac_dest > sim.log 2>&1 \
  || { echo "Build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
# The simulation log decides the result
grep -q "tests failed" sim.log && exit 1 || exit 0

//--- verilog/dmac_address_generator.sv
// AXI write address generator
// Turns burst requests into AW transfers and counts issued bursts,
// holding off while the burst ID window is full

`default_nettype none

module dmac_address_generator #(
  parameter int ID_WIDTH = 3,
  parameter int DATA_WIDTH = 64,
  parameter int ADDR_WIDTH = 32,
  parameter int BEATS_PER_BURST_WIDTH = 4,
  localparam int BYTES_PER_BEAT_WIDTH = $clog2(DATA_WIDTH / 8)
) (
  input  logic                                      m_axi_aclk,
  input  logic                                      rst_n,

  input  logic                                      enable,
  output logic                                      enabled,

  input  logic                                      req_valid,
  output logic                                      req_ready,
  input  logic [ADDR_WIDTH-1:BYTES_PER_BEAT_WIDTH]  req_address,
  input  logic [BEATS_PER_BURST_WIDTH-1:0]          req_last_burst_length,

  input  logic [ID_WIDTH-1:0]                       response_id,
  output logic [ID_WIDTH-1:0]                       address_id,

  output logic                                      m_axi_awvalid,
  input  logic                                      m_axi_awready,
  output logic [ADDR_WIDTH-1:0]                     m_axi_awaddr,
  output logic [dmac_dest_pkg::AXI_LEN_WIDTH-1:0]   m_axi_awlen,
  output logic [2:0]                                m_axi_awsize,
  output dmac_dest_pkg::axi_burst_e                 m_axi_awburst,
  output logic [2:0]                                m_axi_awprot,
  output logic [3:0]                                m_axi_awcache
);

  localparam int LEN_PAD = dmac_dest_pkg::AXI_LEN_WIDTH - BEATS_PER_BURST_WIDTH;

  logic                                     pending;
  logic [ADDR_WIDTH-1:BYTES_PER_BEAT_WIDTH] addr_q;
  logic [BEATS_PER_BURST_WIDTH-1:0]         len_q;
  logic [ID_WIDTH-1:0]                      next_address_id;
  logic                                     id_window_ok;
  logic                                     aw_fire;

  // One slot is kept free so a full window differs from an empty one
  assign next_address_id = address_id + 1'b1;
  assign id_window_ok = next_address_id != response_id;

  // New requests only while enabled and the AW slot is free
  assign req_ready = enable && enabled && !pending;

  // response_id only moves away, so valid holds once raised
  assign m_axi_awvalid = pending && id_window_ok;
  assign aw_fire = m_axi_awvalid && m_axi_awready;

  assign m_axi_awaddr = {addr_q, {BYTES_PER_BEAT_WIDTH{1'b0}}};
  assign m_axi_awlen = {{LEN_PAD{1'b0}}, len_q};
  assign m_axi_awsize = 3'(BYTES_PER_BEAT_WIDTH);
  assign m_axi_awburst = dmac_dest_pkg::INCR;
  assign m_axi_awprot = dmac_dest_pkg::AXI_PROT;
  assign m_axi_awcache = dmac_dest_pkg::AXI_CACHE;

  always_ff @(posedge m_axi_aclk) begin
    if (!rst_n) begin
      pending <= 1'b0;
      address_id <= '0;
      enabled <= 1'b0;
    end else begin
      if (req_valid && req_ready) begin
        pending <= 1'b1;
      end else if (aw_fire) begin
        pending <= 1'b0;
      end

      if (aw_fire) begin
        address_id <= next_address_id;
      end

      // Drain the held burst before dropping enabled
      if (enable) begin
        enabled <= 1'b1;
      end else if (!pending) begin
        enabled <= 1'b0;
      end
    end
  end

  // Burst payload
  always_ff @(posedge m_axi_aclk) begin
    if (req_valid && req_ready) begin
      addr_q <= req_address;
      len_q <= req_last_burst_length;
    end
  end

endmodule

`default_nettype wire

//--- verilog/dmac_data_mover.sv
// AXI write data mover
// Passes FIFO beats to the W channel once the burst's address is out,
// counts beats for WLAST and builds the strobe of the final beat

`default_nettype none

module dmac_data_mover #(
  parameter int ID_WIDTH = 3,
  parameter int DATA_WIDTH = 64,
  parameter int BEATS_PER_BURST_WIDTH = 4,
  localparam int BYTES_PER_BEAT_WIDTH = $clog2(DATA_WIDTH / 8)
) (
  input  logic                             m_axi_aclk,
  input  logic                             rst_n,

  input  logic                             enable,
  output logic                             enabled,

  input  logic                             req_valid,
  output logic                             req_ready,
  input  logic [BEATS_PER_BURST_WIDTH-1:0] req_last_burst_length,
  input  logic [BYTES_PER_BEAT_WIDTH-1:0]  req_last_beat_bytes,
  input  logic                             req_eot,

  input  logic [ID_WIDTH-1:0]              address_id,
  output logic [ID_WIDTH-1:0]              data_id,

  input  logic                             fifo_valid,
  output logic                             fifo_ready,
  input  logic [DATA_WIDTH-1:0]            fifo_data,

  output logic                             m_axi_wvalid,
  input  logic                             m_axi_wready,
  output logic [DATA_WIDTH-1:0]            m_axi_wdata,
  output logic [DATA_WIDTH/8-1:0]          m_axi_wstrb,
  output logic                             m_axi_wlast
);

  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  logic                             pending;
  logic                             active;
  logic                             w_fire;
  logic [BEATS_PER_BURST_WIDTH-1:0] beat_cnt;
  logic [BEATS_PER_BURST_WIDTH-1:0] len_q;
  logic [BYTES_PER_BEAT_WIDTH-1:0]  last_bytes_q;
  logic                             eot_q;
  logic [STRB_WIDTH-1:0]            last_strb;

  // **************************************************
  // Burst control
  // **************************************************

  // W may start only after the AW of this burst has gone out
  assign active = pending && (data_id != address_id);
  assign req_ready = enable && enabled && !pending;

  assign m_axi_wvalid = active && fifo_valid;
  assign m_axi_wdata = fifo_data;
  assign m_axi_wlast = active && (beat_cnt == len_q);
  assign w_fire = m_axi_wvalid && m_axi_wready;

  // Flush the FIFO while disabled
  assign fifo_ready = (active && m_axi_wready) || !enabled;

  // Low last_beat_bytes+1 byte lanes
  always_comb begin
    for (int i = 0; i < STRB_WIDTH; i++) begin
      last_strb[i] = i <= int'(last_bytes_q);
    end
  end

  assign m_axi_wstrb = (eot_q && m_axi_wlast) ? last_strb : {STRB_WIDTH{1'b1}};

  always_ff @(posedge m_axi_aclk) begin
    if (!rst_n) begin
      pending <= 1'b0;
      beat_cnt <= '0;
      data_id <= '0;
      enabled <= 1'b0;
    end else begin
      if (req_valid && req_ready) begin
        pending <= 1'b1;
        beat_cnt <= '0;
      end else if (w_fire) begin
        if (m_axi_wlast) begin
          pending <= 1'b0;
          data_id <= data_id + 1'b1;
        end else begin
          beat_cnt <= beat_cnt + 1'b1;
        end
      end

      // Done once every issued address has its data
      if (enable) begin
        enabled <= 1'b1;
      end else if (data_id == address_id) begin
        enabled <= 1'b0;
      end
    end
  end

  // Burst payload
  always_ff @(posedge m_axi_aclk) begin
    if (req_valid && req_ready) begin
      len_q <= req_last_burst_length;
      last_bytes_q <= req_last_beat_bytes;
      eot_q <= req_eot;
    end
  end

endmodule

`default_nettype wire

//--- verilog/dmac_dest_mm_axi.sv
// DMA destination AXI4 memory-mapped write master
// Splits each burst request to the address, data and response paths
// and chains their enables so a disable drains in order

`default_nettype none

module dmac_dest_mm_axi #(
  parameter int ID_WIDTH = 3,
  parameter int DATA_WIDTH = 64,
  parameter int ADDR_WIDTH = 32,
  parameter int BEATS_PER_BURST_WIDTH = 4,
  localparam int BYTES_PER_BEAT_WIDTH = $clog2(DATA_WIDTH / 8)
) (
  input  logic                                     m_axi_aclk,
  input  logic                                     rst_n,

  input  logic                                     enable,
  output logic                                     enabled,

  input  logic                                     req_valid,
  output logic                                     req_ready,
  input  logic [ADDR_WIDTH-1:BYTES_PER_BEAT_WIDTH] req_address,
  input  logic [BEATS_PER_BURST_WIDTH-1:0]         req_last_burst_length,
  input  logic [BYTES_PER_BEAT_WIDTH-1:0]          req_last_beat_bytes,
  input  logic                                     req_eot,

  input  logic                                     fifo_valid,
  output logic                                     fifo_ready,
  input  logic [DATA_WIDTH-1:0]                    fifo_data,

  // Write address
  output logic                                     m_axi_awvalid,
  input  logic                                     m_axi_awready,
  output logic [ADDR_WIDTH-1:0]                    m_axi_awaddr,
  output logic [dmac_dest_pkg::AXI_LEN_WIDTH-1:0]  m_axi_awlen,
  output logic [2:0]                               m_axi_awsize,
  output dmac_dest_pkg::axi_burst_e                m_axi_awburst,
  output logic [2:0]                               m_axi_awprot,
  output logic [3:0]                               m_axi_awcache,

  // Write data
  output logic                                     m_axi_wvalid,
  input  logic                                     m_axi_wready,
  output logic [DATA_WIDTH-1:0]                    m_axi_wdata,
  output logic [DATA_WIDTH/8-1:0]                  m_axi_wstrb,
  output logic                                     m_axi_wlast,

  // Write response
  input  logic                                     m_axi_bvalid,
  output logic                                     m_axi_bready,
  input  dmac_dest_pkg::axi_resp_e                 m_axi_bresp,

  output logic                                     response_valid,
  input  logic                                     response_ready,
  output dmac_dest_pkg::dest_resp_t                response
);

  // Branch order is address, data, response
  logic [2:0]          split_valid;
  logic [2:0]          split_ready;
  logic                address_enabled;
  logic                data_enabled;
  logic [ID_WIDTH-1:0] address_id;
  logic [ID_WIDTH-1:0] data_id;
  logic [ID_WIDTH-1:0] response_id;

  dmac_req_splitter i_req_splitter (
    .m_axi_aclk (m_axi_aclk),
    .rst_n      (rst_n),
    .s_valid    (req_valid),
    .s_ready    (req_ready),
    .m_valid    (split_valid),
    .m_ready    (split_ready)
  );

  dmac_address_generator #(
    .ID_WIDTH              (ID_WIDTH),
    .DATA_WIDTH            (DATA_WIDTH),
    .ADDR_WIDTH            (ADDR_WIDTH),
    .BEATS_PER_BURST_WIDTH (BEATS_PER_BURST_WIDTH)
  ) i_address_generator (
    .m_axi_aclk            (m_axi_aclk),
    .rst_n                 (rst_n),
    .enable                (enable),
    .enabled               (address_enabled),
    .req_valid             (split_valid[0]),
    .req_ready             (split_ready[0]),
    .req_address           (req_address),
    .req_last_burst_length (req_last_burst_length),
    .response_id           (response_id),
    .address_id            (address_id),
    .m_axi_awvalid         (m_axi_awvalid),
    .m_axi_awready         (m_axi_awready),
    .m_axi_awaddr          (m_axi_awaddr),
    .m_axi_awlen           (m_axi_awlen),
    .m_axi_awsize          (m_axi_awsize),
    .m_axi_awburst         (m_axi_awburst),
    .m_axi_awprot          (m_axi_awprot),
    .m_axi_awcache         (m_axi_awcache)
  );

  dmac_data_mover #(
    .ID_WIDTH              (ID_WIDTH),
    .DATA_WIDTH            (DATA_WIDTH),
    .BEATS_PER_BURST_WIDTH (BEATS_PER_BURST_WIDTH)
  ) i_data_mover (
    .m_axi_aclk            (m_axi_aclk),
    .rst_n                 (rst_n),
    .enable                (address_enabled),
    .enabled               (data_enabled),
    .req_valid             (split_valid[1]),
    .req_ready             (split_ready[1]),
    .req_last_burst_length (req_last_burst_length),
    .req_last_beat_bytes   (req_last_beat_bytes),
    .req_eot               (req_eot),
    .address_id            (address_id),
    .data_id               (data_id),
    .fifo_valid            (fifo_valid),
    .fifo_ready            (fifo_ready),
    .fifo_data             (fifo_data),
    .m_axi_wvalid          (m_axi_wvalid),
    .m_axi_wready          (m_axi_wready),
    .m_axi_wdata           (m_axi_wdata),
    .m_axi_wstrb           (m_axi_wstrb),
    .m_axi_wlast           (m_axi_wlast)
  );

  dmac_response_handler #(
    .ID_WIDTH (ID_WIDTH)
  ) i_response_handler (
    .m_axi_aclk     (m_axi_aclk),
    .rst_n          (rst_n),
    .enable         (data_enabled),
    .enabled        (enabled),
    .req_valid      (split_valid[2]),
    .req_ready      (split_ready[2]),
    .req_eot        (req_eot),
    .data_id        (data_id),
    .response_id    (response_id),
    .m_axi_bvalid   (m_axi_bvalid),
    .m_axi_bready   (m_axi_bready),
    .m_axi_bresp    (m_axi_bresp),
    .response_valid (response_valid),
    .response_ready (response_ready),
    .response       (response)
  );

endmodule

`default_nettype wire

//--- verilog/dmac_dest_pkg.sv
// Shared types of the DMA destination AXI4 write master
// AXI response and burst encodings, fixed AW attributes and the
// upstream response record

`default_nettype none

package dmac_dest_pkg;

  // **************************************************
  // AXI encodings
  // **************************************************

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // Only INCR is ever driven
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } axi_burst_e;

  // AXI4 burst length field
  localparam int AXI_LEN_WIDTH = 8;

  // Unprivileged, secure, data access
  localparam logic [2:0] AXI_PROT = 3'b000;
  // Modifiable and bufferable
  localparam logic [3:0] AXI_CACHE = 4'b0011;

  // **************************************************
  // Upstream response and splitter flags
  // **************************************************

  typedef struct packed {
    axi_resp_e resp;
    logic      eot;
  } dest_resp_t;

  typedef enum logic {
    IDLE    = 1'b0,
    PARTIAL = 1'b1
  } splitter_state_e;

endpackage

`default_nettype wire

//--- verilog/dmac_req_splitter.sv
// Request splitter
// Forks one valid/ready request into three branches and completes the
// upstream handshake once every branch has taken the request

`default_nettype none

module dmac_req_splitter (
  input  logic       m_axi_aclk,
  input  logic       rst_n,
  input  logic       s_valid,
  output logic       s_ready,
  output logic [2:0] m_valid,
  input  logic [2:0] m_ready
);

  dmac_dest_pkg::splitter_state_e acked [3];
  logic [2:0] done;

  // A branch is done if it took the request earlier or takes it now
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      m_valid[i] = s_valid && (acked[i] == dmac_dest_pkg::IDLE);
      done[i] = (acked[i] == dmac_dest_pkg::PARTIAL) || m_ready[i];
    end
    s_ready = s_valid && (&done);
  end

  always_ff @(posedge m_axi_aclk) begin
    for (int i = 0; i < 3; i++) begin
      if (!rst_n) begin
        acked[i] <= dmac_dest_pkg::IDLE;
      end else if (s_ready) begin
        acked[i] <= dmac_dest_pkg::IDLE;
      end else if (m_valid[i] && m_ready[i]) begin
        acked[i] <= dmac_dest_pkg::PARTIAL;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/dmac_response_handler.sv
// AXI write response handler
// Takes B responses in burst order, joins each with the burst's
// end-of-transfer flag and holds it until accepted upstream

`default_nettype none

module dmac_response_handler #(
  parameter int ID_WIDTH = 3
) (
  input  logic                      m_axi_aclk,
  input  logic                      rst_n,

  input  logic                      enable,
  output logic                      enabled,

  input  logic                      req_valid,
  output logic                      req_ready,
  input  logic                      req_eot,

  input  logic [ID_WIDTH-1:0]       data_id,
  output logic [ID_WIDTH-1:0]       response_id,

  input  logic                      m_axi_bvalid,
  output logic                      m_axi_bready,
  input  dmac_dest_pkg::axi_resp_e  m_axi_bresp,

  output logic                      response_valid,
  input  logic                      response_ready,
  output dmac_dest_pkg::dest_resp_t response
);

  localparam int DEPTH = 2 ** ID_WIDTH;

  logic [ID_WIDTH-1:0] req_id;
  logic [ID_WIDTH-1:0] next_req_id;
  logic                eot_mem [DEPTH];
  logic                b_fire;

  // The eot queue is written in request order and read in response order
  assign next_req_id = req_id + 1'b1;
  assign req_ready = next_req_id != response_id;

  // A response is owed for each burst whose data is complete
  assign m_axi_bready = (response_id != data_id) && !response_valid;
  assign b_fire = m_axi_bvalid && m_axi_bready;

  always_ff @(posedge m_axi_aclk) begin
    if (!rst_n) begin
      req_id <= '0;
      response_id <= '0;
      response_valid <= 1'b0;
      enabled <= 1'b0;
    end else begin
      if (req_valid && req_ready) begin
        req_id <= next_req_id;
      end

      if (b_fire) begin
        response_id <= response_id + 1'b1;
        response_valid <= 1'b1;
      end else if (response_ready) begin
        response_valid <= 1'b0;
      end

      if (enable) begin
        enabled <= 1'b1;
      end else if (response_id == data_id && !response_valid) begin
        enabled <= 1'b0;
      end
    end
  end

  always_ff @(posedge m_axi_aclk) begin
    if (req_valid && req_ready) begin
      eot_mem[req_id] <= req_eot;
    end
    if (b_fire) begin
      response.resp <= m_axi_bresp;
      response.eot <= eot_mem[response_id];
    end
  end

endmodule

`default_nettype wire
